// File: sim/fxAluVectors.txt
# ird col dctl actl byte fin ld ftu A D expOut expAlue expCcr (all hex)
# ld=1 loads ccr from ftu before the step, ccr bits are X N Z V C
D041 2 0 1 0 1 1 04 7000 1000 8000 1000 0A
9001 2 0 1 1 1 0 00 0001 0000 FFFF 0000 19
D001 2 0 1 1 1 1 04 00FF 0001 0000 0001 15
D141 2 0 1 0 1 1 04 0000 0000 0000 0000 04
D141 2 0 1 0 1 0 00 0001 0000 0001 0000 00
D141 2 0 1 0 1 0 00 0000 0000 0000 0000 00
D141 2 0 1 0 1 1 14 FFFF 0001 0001 0001 11
9141 2 0 1 0 1 0 00 0001 0003 0001 0003 00
8041 2 0 1 0 1 1 1F 00F0 0F00 0FF0 0F00 10
B141 2 0 1 0 1 0 00 FF00 0F0F F00F 0F0F 18
C041 2 0 1 0 1 1 17 1234 00FF 0034 00FF 10
4880 2 0 1 0 1 0 00 0080 5555 FF80 5555 18
E240 4 0 1 0 1 1 00 8001 0000 C000 8000 19
E340 4 0 1 0 1 0 00 4000 0000 8000 0000 0A
E208 4 0 1 1 1 1 00 0081 1234 0040 091A 11
E388 4 0 1 0 1 1 00 8001 4000 0002 8001 00
E280 4 0 1 0 1 1 00 0003 8000 0001 C000 11
E250 4 0 1 0 1 1 10 0002 0000 8001 8000 08
E310 4 0 1 1 1 1 10 0080 0000 0101 0000 11
E298 4 0 1 0 1 1 00 0001 1234 0000 891A 01
E358 4 0 1 0 1 1 10 4000 0000 8000 0000 18
3041 2 1 1 0 1 1 15 1234 ABCD 1234 ABCD 15
D0C1 2 0 1 0 1 0 00 0010 0020 0030 0020 15

// File: vlog.f
+incdir+hw
hw/fxAluPkg.sv
hw/aluRowDecoder.sv
hw/aluOpSelect.sv
hw/aluCcrTable.sv
hw/aluExecute.sv
hw/aluCcrUnit.sv
hw/fxAlu.sv
sim/clockGen.sv
sim/tbFxAlu.sv

// File: runSim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tbFxAlu -f vlog.f -Mdir obj_dir -o simFxAlu \
    || { echo "Build failed"; exit 1; }
( ./obj_dir/simFxAlu > sim.log 2>&1 || true ) \
    && grep -q "^>>> PASS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: sim/tbFxAlu.sv
// ========================================
// ALU testbench, runs the vector file
// through decode and execute strobes
// ========================================
module tbFxAlu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VECS   = 64;
    localparam int RST_CYCLES = 16;

    logic        clk;
    logic        rst;
    logic        enT3;
    logic        enT4;
    logic [15:0] ird;
    logic [2:0]  aluColumn;
    logic        aluIsByte;
    logic        finish;
    logic        init;
    logic        aluAddrCtrl;
    logic [1:0]  aluDataCtrl;
    logic [15:0] alub;
    logic [15:0] iAddrBus;
    logic [15:0] iDataBus;
    logic        alueClkEn;
    logic        ftu2Ccr;
    logic [15:0] ftu;
    logic [15:0] aluOut;
    logic [15:0] alue;
    logic [7:0]  ccr;
    logic        ze;

    // Columns: ird col dctl actl byte fin ld ftu A D out alue ccr
    logic [15:0] vecs [0:MAX_VECS-1][0:12];
    int          numVecs = 0;
    int          errors = 0;
    bit          loaded = 1'b0;

    clockGen #(.PERIOD(10.0)) clkGen0 (.clk(clk));

    fxAlu dut0 (
        .clk(clk), .rst(rst), .enT3(enT3), .enT4(enT4), .ird(ird),
        .aluColumn(aluColumn), .aluIsByte(aluIsByte), .finish(finish), .init(init),
        .aluAddrCtrl(aluAddrCtrl), .aluDataCtrl(aluDataCtrl), .alub(alub),
        .iAddrBus(iAddrBus), .iDataBus(iDataBus), .alueClkEn(alueClkEn),
        .ftu2Ccr(ftu2Ccr), .ftu(ftu), .aluOut(aluOut), .alue(alue), .ccr(ccr), .ze(ze)
    );

    task automatic checkVal(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic loadVectors();
        int          fd;
        int          n;
        string       lineStr;
        logic [15:0] f [0:12];
        fd = $fopen("sim/fxAluVectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/fxAluVectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && numVecs < MAX_VECS) begin
            lineStr = "";
            n = $fgets(lineStr, fd);
            if (n == 0 || lineStr.len() < 8 || lineStr.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(lineStr, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12]);
            if (n != 13) begin
                $display("Vector line has %0d fields instead of 13: %s", n, lineStr);
                errors++;
                continue;
            end
            for (int k = 0; k < 13; k++) begin
                vecs[numVecs][k] = f[k];
            end
            numVecs++;
        end
        $fclose(fd);
    endtask

    // T3 decode, T4 select, T3 execute, then compare
    task automatic runVector(input int i);
        logic expZe;
        @(negedge clk);
        ird         = vecs[i][0];
        aluColumn   = 3'd0;
        aluDataCtrl = vecs[i][2][1:0];
        aluAddrCtrl = vecs[i][3][0];
        aluIsByte   = vecs[i][4][0];
        finish      = 1'b0;
        // Unselected address source carries the complement
        alub        = vecs[i][3][0] ? vecs[i][8] : ~vecs[i][8];
        iAddrBus    = vecs[i][3][0] ? ~vecs[i][8] : vecs[i][8];
        iDataBus    = vecs[i][9];
        alueClkEn   = 1'b1;          // Preload the high word
        ftu2Ccr     = vecs[i][6][0];
        ftu         = vecs[i][7];
        enT3        = 1'b1;
        @(negedge clk);
        enT3      = 1'b0;
        alueClkEn = 1'b0;
        ftu2Ccr   = 1'b0;
        aluColumn = vecs[i][1][2:0];
        finish    = vecs[i][5][0];
        enT4      = 1'b1;
        @(negedge clk);
        enT4 = 1'b0;
        enT3 = 1'b1;
        @(negedge clk);
        enT3 = 1'b0;
        // Core Z follows the result at operand size
        expZe = aluIsByte ? |vecs[i][10][7:0] : |vecs[i][10];
        checkVal(aluOut, vecs[i][10], $sformatf("vector %0d aluOut", i));
        checkVal(alue, vecs[i][11], $sformatf("vector %0d alue", i));
        checkVal({8'h00, ccr}, vecs[i][12], $sformatf("vector %0d ccr", i));
        checkVal({15'h0000, ze}, {15'h0000, expZe}, $sformatf("vector %0d ze", i));
    endtask

    initial begin
        rst = 1'b1;
        enT3 = 1'b0;
        enT4 = 1'b0;
        ird = 16'h0000;
        aluColumn = 3'd0;
        aluIsByte = 1'b0;
        finish = 1'b0;
        init = 1'b0;
        aluAddrCtrl = 1'b0;
        aluDataCtrl = 2'b00;
        alub = 16'h0000;
        iAddrBus = 16'h0000;
        iDataBus = 16'h0000;
        alueClkEn = 1'b0;
        ftu2Ccr = 1'b0;
        ftu = 16'h0000;
        loadVectors();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkVal({8'h00, ccr}, 16'h0000, "ccr after reset");
        checkVal({15'h0000, ze}, 16'h0001, "ze after reset");
        for (int i = 0; i < numVecs; i++) begin
            runVector(i);
        end
        $display("Ran %0d vectors, %0d errors", numVecs, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        int limit;
        wait (loaded);
        limit = 2 * (numVecs * 8 + RST_CYCLES);
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sim/clockGen.sv
// ========================================
// Testbench clock source
// ========================================
module clockGen #(
    parameter real PERIOD = 10.0
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// File: hw/fxAlu.sv
// ========================================
// 68000 integer ALU top level
// Decode registers, result latches, CCRs
// ========================================
`include "fxAlu_macros.svh"

module fxAlu import fxAluPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        enT3,
    input  logic        enT4,
    input  irdWord_u    ird,
    input  logic [2:0]  aluColumn,
    input  logic        aluIsByte,
    input  logic        finish,
    input  logic        init,
    input  logic        aluAddrCtrl,
    input  logic [1:0]  aluDataCtrl,
    input  logic [15:0] alub,
    input  logic [15:0] iAddrBus,
    input  logic [15:0] iDataBus,
    input  logic        alueClkEn,
    input  logic        ftu2Ccr,
    input  logic [15:0] ftu,
    output logic [15:0] aluOut,
    output logic [15:0] alue,
    output logic [7:0]  ccr,
    output logic        ze
);
    logic [15:0]          decRow;
    logic                 decNoCcrEn;
    logic                 decIsArX;
    logic [15:0]          row;
    logic                 noCcrEn;
    logic                 isArX;
    logic                 isByte;
    logic                 isLong;
    aluOp_e               selOp;
    aluOp_e               aluOp;
    logic [`CCR_BITS-1:0] selMask;
    logic [`CCR_BITS-1:0] ccrMask;
    logic [15:0]          result;
    logic [15:0]          shiftHigh;
    logic [`CCR_BITS-1:0] flags;
    logic [`CCR_BITS-1:0] coreCcr;
    logic [`CCR_BITS-1:0] statusCcr;
    logic                 colActive;

    assign colActive = |aluColumn;

    aluRowDecoder rowDec0 (.ird(ird), .row(decRow), .noCcrEn(decNoCcrEn), .isArX(decIsArX));
    aluOpSelect opSel0 (.row(row), .aluColumn(aluColumn), .aluOp(selOp));
    aluCcrTable ccrTab0 (.row(row), .aluColumn(aluColumn), .finish(finish), .ccrMask(selMask));

    aluExecute exec0 (
        .aluOp(aluOp), .isByte(isByte), .isLong(isLong),
        .aluAddrCtrl(aluAddrCtrl), .aluDataCtrl(aluDataCtrl),
        .alub(alub), .iAddrBus(iAddrBus), .iDataBus(iDataBus), .alue(alue),
        .coreCcr(coreCcr), .statusCcr(statusCcr), .aluColumn(aluColumn),
        .rowRotX(row[8] | row[11]),     // ROXR and ROXL rows
        .result(result), .shiftHigh(shiftHigh), .flags(flags)
    );

    aluCcrUnit ccrUnit0 (
        .clk(clk), .rst(rst),
        .update(enT3 & colActive & ~noCcrEn & (finish | init)),
        .load(enT3 & ftu2Ccr),
        .zOnlyClear(finish | isArX),
        .flags(flags), .ccrMask(ccrMask), .ftu(ftu), .statusCcr(statusCcr)
    );

    // Row on T3, operation and mask on T4
    always_ff @(posedge clk) begin
        if (rst) begin
            row     <= '0;
            noCcrEn <= 1'b0;
            isArX   <= 1'b0;
            isByte  <= 1'b0;
            isLong  <= 1'b0;
            aluOp   <= OP_NONE;
            ccrMask <= '0;
            coreCcr <= '0;
        end else begin
            if (enT3) begin
                row     <= decRow;
                noCcrEn <= decNoCcrEn;
                isArX   <= decIsArX;
                isByte  <= aluIsByte;
            end
            if (enT4) begin
                isLong  <= (ird.shf.size == 2'b10);
                aluOp   <= selOp;
                ccrMask <= selMask;
            end
            if (enT3 && colActive) begin
                coreCcr <= flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enT3 && colActive) begin
            aluOut <= result;
        end
        if (enT3) begin
            if (alueClkEn) begin
                alue <= iDataBus;
            end else if (aluOp[4] && colActive) begin
                alue <= shiftHigh;          // Shift high word
            end
        end
    end

    assign ccr = {3'b000, statusCcr};
    assign ze  = ~coreCcr[`CCR_Z];

endmodule

// File: hw/aluCcrUnit.sv
// ========================================
// Status CCR with masked flag merge
// ========================================
`include "fxAlu_macros.svh"

module aluCcrUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 update,
    input  logic                 load,
    input  logic                 zOnlyClear,
    input  logic [`CCR_BITS-1:0] flags,
    input  logic [`CCR_BITS-1:0] ccrMask,
    input  logic [15:0]          ftu,
    output logic [`CCR_BITS-1:0] statusCcr
);
    logic [`CCR_BITS-1:0] merged;

    always_comb begin
        merged = (flags & ccrMask) | (statusCcr & ~ccrMask);
        if (zOnlyClear) begin
            merged[`CCR_Z] = flags[`CCR_Z] & statusCcr[`CCR_Z];  // Multi-word Z
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            statusCcr <= '0;
        end else if (load) begin
            statusCcr <= ftu[`CCR_BITS-1:0];    // Micro-sequencer wins
        end else if (update) begin
            statusCcr <= merged;
        end
    end

endmodule

// File: hw/aluExecute.sv
// ========================================
// ALU datapath: operands, adder, logic,
// shifter, result mux and raw flags
// ========================================
`include "fxAlu_macros.svh"

module aluExecute import fxAluPkg::*; (
    input  aluOp_e               aluOp,
    input  logic                 isByte,
    input  logic                 isLong,
    input  logic                 aluAddrCtrl,
    input  logic [1:0]           aluDataCtrl,
    input  logic [15:0]          alub,
    input  logic [15:0]          iAddrBus,
    input  logic [15:0]          iDataBus,
    input  logic [15:0]          alue,
    input  logic [`CCR_BITS-1:0] coreCcr,
    input  logic [`CCR_BITS-1:0] statusCcr,
    input  logic [2:0]           aluColumn,
    input  logic                 rowRotX,
    output logic [15:0]          result,
    output logic [15:0]          shiftHigh,
    output logic [`CCR_BITS-1:0] flags
);
    logic [15:0] aOperand;
    logic [15:0] dOperand;
    logic [15:0] aInv;
    logic [16:0] sum;
    logic [15:0] addResult;
    logic        addCin;
    logic        addCout;
    logic        addOv;
    logic        rMsb;
    logic        dMsb;
    logic        shftMsb;
    logic        shftNext;   // Bit below the MSB, for ASL overflow
    logic        shftCin;
    logic [31:0] shftData;
    logic [31:0] shftResult;

    assign aOperand = aluAddrCtrl ? alub : iAddrBus;
    assign dOperand = (aluDataCtrl == 2'b00) ? iDataBus :
                      (aluDataCtrl == 2'b11) ? 16'hffff : 16'h0000;

    // Adder, result is D minus A when subtracting
    always_comb begin
        case (aluOp[2:0])
            3'b011:  addCin = 1'b1;
            3'b100:  addCin = coreCcr[`CCR_C];
            3'b101:  addCin = ~coreCcr[`CCR_C];
            3'b110:  addCin = statusCcr[`CCR_X];
            3'b111:  addCin = ~statusCcr[`CCR_X];
            default: addCin = 1'b0;
        endcase
        aInv = aOperand ^ {16{aluOp[0]}};
        sum  = {1'b0, dOperand} + {1'b0, aInv} + {16'h0000, addCin};
        if (isByte) begin
            addResult = {{8{sum[7]}}, sum[7:0]};
            addCout   = sum[8] ^ dOperand[8] ^ aInv[8];
            rMsb      = sum[7];
            dMsb      = dOperand[7];
            addOv     = (aInv[7] & dMsb & ~rMsb) | (~aInv[7] & ~dMsb & rMsb);
        end else begin
            addResult = sum[15:0];
            addCout   = sum[16];
            rMsb      = sum[15];
            dMsb      = dOperand[15];
            addOv     = (aInv[15] & dMsb & ~rMsb) | (~aInv[15] & ~dMsb & rMsb);
        end
    end

    // Shifter over the alue:A pair
    assign shftMsb  = isLong ? alue[15] : (isByte ? aOperand[7] : aOperand[15]);
    assign shftNext = isLong ? alue[14] : (isByte ? aOperand[6] : aOperand[14]);

    always_comb begin
        case (aluOp)
            OP_ROL, OP_ASR:   shftCin = shftMsb;
            OP_ROR:           shftCin = aOperand[0];
            OP_ROXL, OP_ROXR: shftCin = statusCcr[`CCR_X];
            default:          shftCin = 1'b0;
        endcase
        shftData = {alue, aOperand};
        if (isByte && aluOp[0]) begin
            shftData[8] = shftCin;      // Enters at bit 7
        end else if (!isLong && aluOp[0]) begin
            shftData[16] = shftCin;     // Enters at bit 15
        end
        shftResult = aluOp[0] ? {shftCin, shftData[31:1]} : {shftData[30:0], shftCin};
    end

    assign shiftHigh = shftResult[31:16];

    always_comb begin
        case (aluOp)
            OP_OR:   result = aOperand | dOperand;
            OP_EOR:  result = aOperand ^ dOperand;
            OP_AND:  result = aOperand & dOperand;
            OP_EXT:  result = {{8{aOperand[7]}}, aOperand[7:0]};
            OP_SUB0, OP_ADD, OP_SUB, OP_ADDC,
            OP_SUBC, OP_ADDX, OP_SUBX: result = addResult;
            default: result = aluOp[4] ? shftResult[15:0] : 16'h0000;
        endcase
    end

    always_comb begin
        flags = '0;
        flags[`CCR_X] = statusCcr[`CCR_X];
        flags[`CCR_Z] = isByte ? ~(|result[7:0]) : ~(|result);
        flags[`CCR_N] = isByte ? result[7] : result[15];
        case (aluOp)
            // ROX with zero count copies X to C
            OP_AND: flags[`CCR_C] = (aluColumn == 3'd1) && rowRotX && statusCcr[`CCR_X];
            OP_ADD, OP_SUB, OP_ADDC, OP_SUBC, OP_ADDX, OP_SUBX: begin
                flags[`CCR_C] = addCout ^ aluOp[0];   // Borrow on subtract
                flags[`CCR_X] = addCout ^ aluOp[0];
                flags[`CCR_V] = addOv;
            end
            OP_ASL, OP_LSL, OP_ROXL: begin
                flags[`CCR_C] = shftMsb;
                flags[`CCR_X] = shftMsb;
                // Sticky over the shift loop
                flags[`CCR_V] = (aluOp == OP_ASL) && (statusCcr[`CCR_V] || (shftMsb ^ shftNext));
            end
            OP_ASR, OP_LSR, OP_ROXR: begin
                flags[`CCR_C] = aOperand[0];
                flags[`CCR_X] = aOperand[0];
            end
            OP_ROL:  flags[`CCR_C] = shftMsb;
            OP_ROR:  flags[`CCR_C] = aOperand[0];
            default: flags[`CCR_C] = 1'b0;          // Logic ops clear V and C
        endcase
    end

endmodule

// File: hw/aluCcrTable.sv
// ========================================
// CCR update mask by row and column
// ========================================
`include "fxAlu_macros.svh"

module aluCcrTable (
    input  logic [15:0]          row,
    input  logic [2:0]           aluColumn,
    input  logic                 finish,
    output logic [`CCR_BITS-1:0] ccrMask
);

    always_comb begin
        ccrMask = '0;
        case (aluColumn)
            3'd1: ccrMask = finish ? `MASK_KNZKK :
                            ((row[13] || row[14]) ? `MASK_KKZKK : `MASK_KNZ00);
            3'd2, 3'd3: begin
                case (1'b1)
                    row[2], row[3], row[5],
                    row[9], row[10], row[12]: ccrMask = `MASK_ALL;
                    row[6], row[11]:          ccrMask = `MASK_KNZVC;  // CMP, NOT
                    row[4], row[8],
                    row[13], row[14]:         ccrMask = `MASK_KNZ00;
                    default:                  ccrMask = '0;            // TAS, Scc
                endcase
            end
            3'd4: begin
                case (row)
                    `ROW_02, `ROW_03, `ROW_04, `ROW_05,
                    `ROW_08, `ROW_11: ccrMask = `MASK_ALL;
                    `ROW_09, `ROW_10: ccrMask = `MASK_KNZ00;  // ROL/ROR keep X
                    default:          ccrMask = '0;
                endcase
            end
            default: ccrMask = '0;
        endcase
    end

endmodule

// File: hw/aluOpSelect.sv
// ========================================
// ALU operation lookup by row and column
// ========================================
module aluOpSelect import fxAluPkg::*; (
    input  logic [15:0] row,
    input  logic [2:0]  aluColumn,
    output aluOp_e      aluOp
);

    // Picks the entry for columns 2, 3 and 4 of a row
    function automatic aluOp_e byCol(input logic [2:0] col, input aluOp_e op2,
                                     input aluOp_e op3, input aluOp_e op4);
        aluOp_e op;
        case (col)
            3'd2:    op = op2;
            3'd3:    op = op3;
            3'd4:    op = op4;
            default: op = OP_NONE;
        endcase
        return op;
    endfunction

    always_comb begin
        aluOp = OP_NONE;
        case (aluColumn)
            3'd1: aluOp = OP_AND;
            3'd5: aluOp = OP_EXT;
            default: begin
                case (1'b1)
                    row[2]:  aluOp = byCol(aluColumn, OP_ADD, OP_ADDC, OP_ASR);
                    row[3]:  aluOp = byCol(aluColumn, OP_ADDX, OP_ADD, OP_ASL);
                    row[4]:  aluOp = (aluColumn == 3'd4) ? OP_LSL : OP_AND;
                    row[5],
                    row[6]:  aluOp = byCol(aluColumn, OP_SUB, OP_SUBC, OP_LSR);
                    row[8]:  aluOp = byCol(aluColumn, OP_EXT, OP_AND, OP_ROXR);
                    row[9]:  aluOp = byCol(aluColumn, OP_SUBX, OP_NONE, OP_ROL);
                    row[10]: aluOp = byCol(aluColumn, OP_SUBX, OP_SUBC, OP_ROR);
                    row[11]: aluOp = byCol(aluColumn, OP_SUB0, OP_SUB0, OP_ROXL);
                    row[12]: aluOp = OP_ADDX;
                    row[13]: aluOp = OP_EOR;
                    row[14]: aluOp = (aluColumn == 3'd4) ? OP_EOR : OP_OR;
                    row[15]: aluOp = (aluColumn == 3'd3) ? OP_ADD : OP_OR;  // ADD for DBcc
                    default: aluOp = OP_NONE;
                endcase
            end
        endcase
    end

endmodule

// File: hw/aluRowDecoder.sv
// ========================================
// ALU row decoder
// Instruction word to one-hot ALU row
// ========================================
`include "fxAlu_macros.svh"

module aluRowDecoder import fxAluPkg::*; (
    input  irdWord_u    ird,
    output logic [15:0] row,
    output logic        noCcrEn,
    output logic        isArX
);
    logic       eaRdir;   // Dn or An direct
    logic       eaAdir;   // An direct
    logic       size11;
    logic [1:0] sType;
    logic       dir;

    assign eaRdir = (ird.gen.eaMode[2:1] == 2'b00);
    assign eaAdir = (ird.gen.eaMode == 3'b001);
    assign size11 = &ird.gen.size;
    assign dir    = ird.gen.dir;
    // Memory shifts keep the type in the count field
    assign sType  = size11 ? ird.shf.count[1:0] : ird.shf.sType;

    always_comb begin
        row = 16'h0000;
        case (ird.gen.line)
            4'h0: begin
                if (dir || ird.gen.rx == 3'b100) begin
                    row = ird.gen.size[1] ? `ROW_14 : `ROW_13;  // Bit ops
                end else begin
                    case (ird.gen.rx)
                        3'b000:  row = `ROW_14;  // ORI
                        3'b001:  row = `ROW_04;  // ANDI
                        3'b010:  row = `ROW_05;  // SUBI
                        3'b011:  row = `ROW_02;  // ADDI
                        3'b101:  row = `ROW_13;  // EORI
                        3'b110:  row = `ROW_06;  // CMPI
                        default: row = 16'h0000;
                    endcase
                end
            end
            4'h1, 4'h2, 4'h3, 4'h7: row = `ROW_02;   // MOVE, MOVEQ
            4'h4: begin
                if (dir) begin
                    row = `ROW_06;                  // CHK
                end else begin
                    case (ird.gen.rx)
                        3'b000:  row = `ROW_10;      // NEGX
                        3'b001:  row = `ROW_04;      // CLR
                        3'b010:  row = `ROW_05;      // NEG
                        3'b011:  row = `ROW_11;      // NOT
                        3'b101:  row = `ROW_15;      // TST, TAS
                        // EXT or SWAP, NBCD has no row
                        3'b100:  row = ird.gen.size[1] ? `ROW_08 :
                                       (ird.gen.size[0] ? `ROW_09 : 16'h0000);
                        default: row = 16'h0000;
                    endcase
                end
            end
            4'h5: row = size11 ? `ROW_15 : (dir ? `ROW_05 : `ROW_02);
            4'h8: row = (size11 || (dir && eaRdir)) ? 16'h0000 : `ROW_14;  // OR only
            4'h9: row = (dir && !size11 && eaRdir) ? `ROW_10 : `ROW_05;   // SUBX or SUB
            4'hb: row = (dir && !size11 && !eaAdir) ? `ROW_13 : `ROW_06;  // EOR or CMP
            4'hc: row = (size11 || (dir && eaRdir)) ? 16'h0000 : `ROW_04;  // AND only
            4'hd: row = (dir && !size11 && eaRdir) ? `ROW_12 : `ROW_02;   // ADDX or ADD
            4'he: begin
                case ({sType, ird.shf.dir})
                    3'd0: row = `ROW_02;  // ASR
                    3'd1: row = `ROW_03;  // ASL
                    3'd2: row = `ROW_05;  // LSR
                    3'd3: row = `ROW_04;  // LSL
                    3'd4: row = `ROW_08;  // ROXR
                    3'd5: row = `ROW_11;  // ROXL
                    3'd6: row = `ROW_10;  // ROR
                    3'd7: row = `ROW_09;  // ROL
                endcase
            end
            default: row = 16'h0000;
        endcase
    end

    // NEGX, SUBX and ADDX only clear Z
    assign isArX = (ird.gen.line == 4'h4 || ird.gen.line == 4'h9 || ird.gen.line == 4'hd)
                   && (row[10] || row[12]);

    // ADDA/SUBA, ADDQ/SUBQ to An, MOVEA
    assign noCcrEn = ((ird.gen.line == 4'h9 || ird.gen.line == 4'hd) && size11)
                   || (ird.gen.line == 4'h5 && eaAdir)
                   || ((ird.gen.line == 4'h2 || ird.gen.line == 4'h3)
                       && {dir, ird.gen.size} == 3'b001);

endmodule

// File: hw/fxAluPkg.sv
// ========================================
// ALU types: operation codes and the
// instruction word in its two layouts
// ========================================
package fxAluPkg;

    // Grouping: 001xx logic, 01xxx adder, 1xxxx shifter
    typedef enum logic [4:0] {
        OP_NONE = 5'd0,
        OP_OR   = 5'd4,
        OP_EOR  = 5'd5,
        OP_AND  = 5'd6,
        OP_EXT  = 5'd7,
        OP_SUB0 = 5'd9,   // NOT
        OP_ADD  = 5'd10,
        OP_SUB  = 5'd11,
        OP_ADDC = 5'd12,
        OP_SUBC = 5'd13,
        OP_ADDX = 5'd14,
        OP_SUBX = 5'd15,
        OP_ASL  = 5'd16,
        OP_ASR  = 5'd17,
        OP_LSL  = 5'd18,
        OP_LSR  = 5'd19,
        OP_ROL  = 5'd20,
        OP_ROR  = 5'd21,
        OP_ROXL = 5'd22,
        OP_ROXR = 5'd23
    } aluOp_e;

    typedef union packed {
        struct packed {
            logic [3:0] line;
            logic [2:0] rx;
            logic       dir;     // Also the opmode high bit
            logic [1:0] size;
            logic [2:0] eaMode;
            logic [2:0] eaReg;
        } gen;
        struct packed {
            logic [3:0] line;
            logic [2:0] count;   // Count or count register
            logic       dir;     // 1 shifts left
            logic [1:0] size;
            logic       ir;      // Count from register
            logic [1:0] sType;
            logic [2:0] ry;
        } shf;
    } irdWord_u;

endpackage

// File: hw/fxAlu_macros.svh
// ========================================
// ALU constants: row codes, CCR bits, masks
// ========================================
`ifndef FXALU_MACROS_SVH
`define FXALU_MACROS_SVH

`define CCR_BITS 5
`define CCR_C 0
`define CCR_V 1
`define CCR_Z 2
`define CCR_N 3
`define CCR_X 4

// One-hot ALU rows, bit 0 is row zero
`define ROW_01 16'h0002
`define ROW_02 16'h0004
`define ROW_03 16'h0008
`define ROW_04 16'h0010
`define ROW_05 16'h0020
`define ROW_06 16'h0040
`define ROW_07 16'h0080
`define ROW_08 16'h0100
`define ROW_09 16'h0200
`define ROW_10 16'h0400
`define ROW_11 16'h0800
`define ROW_12 16'h1000
`define ROW_13 16'h2000
`define ROW_14 16'h4000
`define ROW_15 16'h8000

// Mask order is X N Z V C
`define MASK_KNZ00 5'b01111  // V and C come in cleared
`define MASK_KNZKK 5'b01100
`define MASK_KKZKK 5'b00100
`define MASK_KNZVC 5'b01111
`define MASK_ALL   5'b11111

`endif
